// ==== common/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // 4-way, 16 sets, 8 words per line
    localparam int num_ways    = 4;
    localparam int num_sets    = 16;
    localparam int line_words  = 8;
    localparam int word_bytes  = 4;
    localparam int way_bits    = 2;
    localparam int index_bits  = 4;
    localparam int offset_bits = 3;
    localparam int align_bits  = 2;
    localparam int tag_bits    = 23;

    typedef logic [8*word_bytes-1:0] word_t;
    typedef logic [word_bytes-1:0]   strobe_t;
    typedef logic [way_bits-1:0]     way_t;
    typedef logic [index_bits-1:0]   index_t;
    typedef logic [offset_bits-1:0]  offset_t;
    typedef logic [tag_bits-1:0]     tag_t;

    // tree bits, one set
    typedef logic [num_ways-2:0] plru_t;

    // one word in the data array
    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } data_addr_t;

    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [align_bits-1:0] align;
    } addr_fields_t;

    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t fields;
    } cache_addr_u;

    // zero strobe is a read
    typedef struct packed {
        logic        valid;
        cache_addr_u addr;
        strobe_t     strobe;
        word_t       data;
    } dbus_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

    typedef struct packed {
        logic        valid;
        logic        is_write;
        cache_addr_u addr;
        word_t       data;
    } cbus_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } cbus_resp_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        FETCH
    } miss_state_t;

endpackage

`default_nettype wire

// ==== dcache/dcache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array (
    input  logic               clk,
    input  logic               resetn,
    input  dcache_pkg::index_t req_index,
    input  dcache_pkg::tag_t   req_tag,
    input  logic               fill_en,
    input  dcache_pkg::way_t   fill_way,
    output logic               hit,
    output dcache_pkg::way_t   hit_way,
    input  dcache_pkg::way_t   victim_way,
    output logic               victim_valid,
    output dcache_pkg::tag_t   victim_tag
);
    import dcache_pkg::*;

    logic [num_sets-1:0][num_ways-1:0] valid_bits;
    tag_t                              tags [num_sets][num_ways];
    logic [num_ways-1:0]               way_match;

    // all ways of the set compared at once
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            way_match[w] = valid_bits[req_index][w] && (tags[req_index][w] == req_tag);
            if (way_match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit = |way_match;

    assign victim_valid = valid_bits[req_index][victim_way];
    assign victim_tag   = tags[req_index][victim_way];

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_bits <= '0;
        end else if (fill_en) begin
            valid_bits[req_index][fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[req_index][fill_way] <= req_tag;
        end
    end

endmodule

`default_nettype wire

// ==== dcache/dcache_plru.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_plru (
    input  logic               clk,
    input  logic               resetn,
    input  dcache_pkg::index_t req_index,
    input  logic               touch,
    input  dcache_pkg::way_t   touch_way,
    output dcache_pkg::way_t   victim_way
);
    import dcache_pkg::*;

    plru_t [num_sets-1:0] tree;
    plru_t                cur;
    plru_t                next;

    assign cur = tree[req_index];

    // bit 0 picks the half, bits 1 and 2 the way inside it
    assign victim_way = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

    always_comb begin
        next    = cur;
        next[0] = ~touch_way[1];
        if (touch_way[1]) begin
            next[2] = ~touch_way[0];
        end else begin
            next[1] = ~touch_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            tree <= '0;
        end else if (touch) begin
            tree[req_index] <= next;
        end
    end

endmodule

`default_nettype wire

// ==== dcache/dcache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array (
    input  logic                   clk,
    input  logic                   p1_en,
    input  dcache_pkg::strobe_t    p1_strobe,
    input  dcache_pkg::data_addr_t p1_addr,
    input  dcache_pkg::word_t      p1_wdata,
    output dcache_pkg::word_t      p1_rdata,
    input  logic                   p2_en,
    input  dcache_pkg::strobe_t    p2_strobe,
    input  dcache_pkg::data_addr_t p2_addr,
    input  dcache_pkg::word_t      p2_wdata,
    output dcache_pkg::word_t      p2_rdata
);
    import dcache_pkg::*;

    word_t mem [num_ways*num_sets*line_words];

    // read returns the old word when the same port writes
    always_ff @(posedge clk) begin
        if (p1_en) begin
            p1_rdata <= mem[p1_addr];
            for (int b = 0; b < word_bytes; b++) begin
                if (p1_strobe[b]) begin
                    mem[p1_addr][8*b +: 8] <= p1_wdata[8*b +: 8];
                end
            end
        end
        if (p2_en) begin
            p2_rdata <= mem[p2_addr];
            for (int b = 0; b < word_bytes; b++) begin
                if (p2_strobe[b]) begin
                    mem[p2_addr][8*b +: 8] <= p2_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dcache/dcache_miss_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_ctrl (
    input  logic                   clk,
    input  logic                   resetn,
    input  dcache_pkg::dbus_req_t  dreq,
    input  logic                   hit,
    input  dcache_pkg::way_t       hit_way,
    input  dcache_pkg::way_t       victim_way,
    input  logic                   victim_valid,
    input  dcache_pkg::tag_t       victim_tag,
    output logic                   fill_en,
    output dcache_pkg::way_t       fill_way,
    output logic                   touch,
    output logic                   p2_en,
    output dcache_pkg::strobe_t    p2_strobe,
    output dcache_pkg::data_addr_t p2_addr,
    output dcache_pkg::word_t      p2_wdata,
    input  dcache_pkg::word_t      p2_rdata,
    input  dcache_pkg::word_t      p1_rdata,
    output dcache_pkg::dbus_resp_t dresp,
    output dcache_pkg::cbus_req_t  dcreq,
    input  dcache_pkg::cbus_resp_t dcresp
);
    import dcache_pkg::*;

    miss_state_t                       state;
    logic [num_sets-1:0][num_ways-1:0] dirty;
    offset_t                           beat;
    logic                              rd_ok;
    logic                              data_ok;
    logic                              accept;
    logic                              victim_dirty;
    logic                              beat_done;
    index_t                            req_index;
    cache_addr_u                       burst_addr;

    assign req_index    = dreq.addr.fields.index;
    assign accept       = dreq.valid && (state == IDLE) && hit;
    assign victim_dirty = victim_valid && dirty[req_index][victim_way];
    assign beat_done    = dcreq.valid && dcresp.ready;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= IDLE;
            beat  <= '0;
            rd_ok <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    beat  <= '0;
                    rd_ok <= 1'b0;
                    if (dreq.valid && !hit) begin
                        state <= victim_dirty ? WRITEBACK : FETCH;
                    end
                end
                WRITEBACK: begin
                    // word is read one cycle ahead of its beat
                    if (beat_done) begin
                        rd_ok <= 1'b0;
                        beat  <= beat + offset_t'(1);
                        if (dcresp.last) begin
                            beat  <= '0;
                            state <= FETCH;
                        end
                    end else begin
                        rd_ok <= 1'b1;
                    end
                end
                FETCH: begin
                    if (beat_done) begin
                        beat <= beat + offset_t'(1);
                        if (dcresp.last) begin
                            beat  <= '0;
                            state <= IDLE;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            dirty <= '0;
        end else if (accept && |dreq.strobe) begin
            dirty[req_index][hit_way] <= 1'b1;
        end else if (fill_en) begin
            dirty[req_index][victim_way] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= accept;
        end
    end

    // refill writes and write-back reads share port 2
    assign p2_en     = ((state == WRITEBACK) && !rd_ok) || ((state == FETCH) && dcresp.ready);
    assign p2_strobe = (state == FETCH) ? '1 : '0;
    assign p2_addr   = {victim_way, req_index, beat};
    assign p2_wdata  = dcresp.data;

    assign fill_en  = (state == FETCH) && dcresp.ready && dcresp.last;
    assign fill_way = victim_way;
    assign touch    = accept;

    // line aligned, tag of the victim while writing back
    always_comb begin
        burst_addr.fields.tag    = (state == WRITEBACK) ? victim_tag : dreq.addr.fields.tag;
        burst_addr.fields.index  = req_index;
        burst_addr.fields.offset = '0;
        burst_addr.fields.align  = '0;
    end

    assign dcreq.valid    = (state == FETCH) || ((state == WRITEBACK) && rd_ok);
    assign dcreq.is_write = (state == WRITEBACK);
    assign dcreq.addr     = burst_addr;
    assign dcreq.data     = p2_rdata;

    assign dresp.addr_ok = accept;
    assign dresp.data_ok = data_ok;
    assign dresp.data    = p1_rdata;

endmodule

`default_nettype wire

// ==== dcache/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                   clk,
    input  logic                   resetn,
    input  dcache_pkg::dbus_req_t  dreq,
    output dcache_pkg::dbus_resp_t dresp,
    output dcache_pkg::cbus_req_t  dcreq,
    input  dcache_pkg::cbus_resp_t dcresp
);
    import dcache_pkg::*;

    logic       hit;
    way_t       hit_way;
    way_t       victim_way;
    logic       victim_valid;
    tag_t       victim_tag;
    logic       fill_en;
    way_t       fill_way;
    logic       touch;
    logic       p2_en;
    strobe_t    p2_strobe;
    data_addr_t p2_addr;
    word_t      p2_wdata;
    word_t      p2_rdata;
    word_t      p1_rdata;

    dcache_tag_array u_tag_array (
        .clk          (clk),
        .resetn       (resetn),
        .req_index    (dreq.addr.fields.index),
        .req_tag      (dreq.addr.fields.tag),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_valid (victim_valid),
        .victim_tag   (victim_tag)
    );

    dcache_plru u_plru (
        .clk        (clk),
        .resetn     (resetn),
        .req_index  (dreq.addr.fields.index),
        .touch      (touch),
        .touch_way  (hit_way),
        .victim_way (victim_way)
    );

    // port 1 serves the accepted hit
    dcache_data_array u_data_array (
        .clk       (clk),
        .p1_en     (dresp.addr_ok),
        .p1_strobe (dreq.strobe),
        .p1_addr   ({hit_way, dreq.addr.fields.index, dreq.addr.fields.offset}),
        .p1_wdata  (dreq.data),
        .p1_rdata  (p1_rdata),
        .p2_en     (p2_en),
        .p2_strobe (p2_strobe),
        .p2_addr   (p2_addr),
        .p2_wdata  (p2_wdata),
        .p2_rdata  (p2_rdata)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .dreq         (dreq),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_valid (victim_valid),
        .victim_tag   (victim_tag),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .touch        (touch),
        .p2_en        (p2_en),
        .p2_strobe    (p2_strobe),
        .p2_addr      (p2_addr),
        .p2_wdata     (p2_wdata),
        .p2_rdata     (p2_rdata),
        .p1_rdata     (p1_rdata),
        .dresp        (dresp),
        .dcreq        (dcreq),
        .dcresp       (dcresp)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int half_period  = 4,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // reset is active high, released on a rising edge
    initial begin
        resetn = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        resetn <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== verif/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
    parameter dcache_pkg::word_t fill_pattern = 32'h0
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  dcache_pkg::cbus_req_t  dcreq,
    output dcache_pkg::cbus_resp_t dcresp,
    output int                     fetch_count,
    output int                     wb_count
);
    import dcache_pkg::*;

    localparam int mem_words = 8192;

    word_t       mem [mem_words];
    offset_t     beat;
    logic [1:0]  tick;
    logic [12:0] word_idx;
    logic        beat_done;

    assign word_idx  = {dcreq.addr.raw[14:5], beat};
    assign beat_done = dcreq.valid && dcresp.ready;

    // stalls one cycle in four
    always_comb begin
        dcresp.ready = dcreq.valid && (tick != 2'b11);
        dcresp.last  = (beat == offset_t'(line_words - 1));
        dcresp.data  = mem[word_idx];
    end

    always @(posedge clk) begin
        if (resetn) begin
            beat        <= '0;
            tick        <= '0;
            fetch_count <= 0;
            wb_count    <= 0;
            // each word starts as its byte address mixed with the pattern
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= word_t'(i * word_bytes) ^ fill_pattern;
            end
        end else begin
            tick <= tick + 2'd1;
            if (beat_done) begin
                // wraps back to 0 after the last beat
                beat <= beat + 3'd1;
                if (dcreq.is_write) begin
                    mem[word_idx] <= dcreq.data;
                end
                if (dcresp.last) begin
                    if (dcreq.is_write) begin
                        wb_count <= wb_count + 1;
                    end else begin
                        fetch_count <= fetch_count + 1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    typedef struct {
        logic [31:0] addr;
        strobe_t     strobe;
        word_t       data;
        word_t       exp_word;
        int          exp_fetch;
        int          exp_wb;
    } entry_t;

    localparam int    num_entries  = 21;
    localparam int    reset_cycles = 5;
    localparam int    entry_cycles = 200;
    localparam word_t fill_pattern = 32'h5a3c_96e1;

    // set 8 and set 0 for plain hits, set 5 for replacement, set 7 for write-back
    logic [31:0] stim_addr [num_entries] = '{
        32'h0000_0104, 32'h0000_0108, 32'h0000_0104, 32'h0000_0108, 32'h0000_0108,
        32'h0000_3c10, 32'h0000_3c10,
        32'h0000_20a0, 32'h0000_22a4, 32'h0000_24a8, 32'h0000_26ac, 32'h0000_20b0,
        32'h0000_28a0, 32'h0000_20a0, 32'h0000_22a4,
        32'h0000_40e4, 32'h0000_42e0, 32'h0000_44e0, 32'h0000_46e0, 32'h0000_48e0,
        32'h0000_40e4
    };
    strobe_t stim_strobe [num_entries] = '{
        4'b0000, 4'b0000, 4'b0000, 4'b0110, 4'b0000,
        4'b1001, 4'b0000,
        4'b0000, 4'b0000, 4'b0000, 4'b0000, 4'b0000,
        4'b0000, 4'b0000, 4'b0000,
        4'b1111, 4'b0000, 4'b0000, 4'b0000, 4'b0000,
        4'b0000
    };

    logic       clk;
    logic       resetn;
    dbus_req_t  dreq;
    dbus_resp_t dresp;
    cbus_req_t  dcreq;
    cbus_resp_t dcresp;
    int         fetch_count;
    int         wb_count;
    int         seed = 84;

    entry_t entries [num_entries];
    word_t  ref_mem [logic [31:0]];
    tag_t   m_tag   [num_sets][num_ways];
    logic   m_valid [num_sets][num_ways];
    logic   m_dirty [num_sets][num_ways];
    plru_t  m_plru  [num_sets];

    tb_clock_gen #(
        .half_period  (4),
        .reset_cycles (reset_cycles)
    ) u_clock_gen (
        .clk    (clk),
        .resetn (resetn)
    );

    dcache_top u_dcache_top (
        .clk    (clk),
        .resetn (resetn),
        .dreq   (dreq),
        .dresp  (dresp),
        .dcreq  (dcreq),
        .dcresp (dcresp)
    );

    mem_model #(
        .fill_pattern (fill_pattern)
    ) u_mem_model (
        .clk         (clk),
        .resetn      (resetn),
        .dcreq       (dcreq),
        .dcresp      (dcresp),
        .fetch_count (fetch_count),
        .wb_count    (wb_count)
    );

    function automatic way_t plru_pick(plru_t bits);
        if (bits[0]) begin
            return bits[2] ? way_t'(3) : way_t'(2);
        end
        return bits[1] ? way_t'(1) : way_t'(0);
    endfunction

    // bits on the path point away from the touched way
    function automatic plru_t plru_touch(plru_t bits, way_t way);
        case (way)
            2'd0:    return {bits[2], 2'b11};
            2'd1:    return {bits[2], 2'b01};
            2'd2:    return {1'b1, bits[1], 1'b0};
            default: return {1'b0, bits[1], 1'b0};
        endcase
    endfunction

    function automatic word_t ref_word(logic [31:0] addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return addr ^ fill_pattern;
    endfunction

    // expected words and burst counts from a reference memory and cache model
    task automatic build_table();
        cache_addr_u ca;
        logic [31:0] word_addr;
        word_t       merged;
        way_t        way;
        logic        found;
        int          fetches;
        int          writebacks;
        fetches    = 0;
        writebacks = 0;
        for (int s = 0; s < num_sets; s++) begin
            m_plru[s] = '0;
            for (int w = 0; w < num_ways; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        for (int i = 0; i < num_entries; i++) begin
            ca.raw                = stim_addr[i];
            word_addr             = {stim_addr[i][31:2], 2'b00};
            entries[i].addr       = stim_addr[i];
            entries[i].strobe     = stim_strobe[i];
            entries[i].data       = $random(seed);
            entries[i].exp_word   = ref_word(word_addr);
            found = 1'b0;
            way   = '0;
            for (int w = 0; w < num_ways; w++) begin
                if (m_valid[ca.fields.index][w] && m_tag[ca.fields.index][w] == ca.fields.tag) begin
                    found = 1'b1;
                    way   = way_t'(w);
                end
            end
            if (!found) begin
                way = plru_pick(m_plru[ca.fields.index]);
                if (m_valid[ca.fields.index][way] && m_dirty[ca.fields.index][way]) begin
                    writebacks++;
                end
                fetches++;
                m_valid[ca.fields.index][way] = 1'b1;
                m_dirty[ca.fields.index][way] = 1'b0;
                m_tag[ca.fields.index][way]   = ca.fields.tag;
            end
            m_plru[ca.fields.index] = plru_touch(m_plru[ca.fields.index], way);
            if (|stim_strobe[i]) begin
                m_dirty[ca.fields.index][way] = 1'b1;
                merged = entries[i].exp_word;
                for (int b = 0; b < word_bytes; b++) begin
                    if (stim_strobe[i][b]) begin
                        merged[8*b +: 8] = entries[i].data[8*b +: 8];
                    end
                end
                ref_mem[word_addr] = merged;
            end
            entries[i].exp_fetch = fetches;
            entries[i].exp_wb    = writebacks;
        end
    endtask

    task automatic report_mismatch(string msg);
        $display("ERROR @%0t: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic compare_word(string what, word_t got, word_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic compare_count(string what, int got, int exp);
        if (got != exp) begin
            report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic compare_ctrl(string what, cbus_req_t got, cbus_req_t exp);
        if (got.valid !== exp.valid || got.is_write !== exp.is_write) begin
            report_mismatch($sformatf("%s: valid %b is_write %b, expected %b %b",
                what, got.valid, got.is_write, exp.valid, exp.is_write));
        end
    endtask

    task automatic compare_handshake(string what, dbus_resp_t got, dbus_resp_t exp);
        if (got.addr_ok !== exp.addr_ok || got.data_ok !== exp.data_ok) begin
            report_mismatch($sformatf("%s: addr_ok %b data_ok %b, expected %b %b",
                what, got.addr_ok, got.data_ok, exp.addr_ok, exp.data_ok));
        end
    endtask

    // request held until addr_ok, result taken with data_ok
    task automatic run_request(int i);
        dbus_req_t req;
        req          = '0;
        req.valid    = 1'b1;
        req.addr.raw = entries[i].addr;
        req.strobe   = entries[i].strobe;
        req.data     = entries[i].data;
        @(posedge clk);
        dreq <= req;
        @(negedge clk);
        while (!dresp.addr_ok) begin
            @(negedge clk);
        end
        @(posedge clk);
        dreq.valid <= 1'b0;
        @(negedge clk);
        while (!dresp.data_ok) begin
            @(negedge clk);
        end
        compare_word($sformatf("entry %0d data", i), dresp.data, entries[i].exp_word);
        compare_count($sformatf("entry %0d fetch bursts", i), fetch_count, entries[i].exp_fetch);
        compare_count($sformatf("entry %0d write-back bursts", i), wb_count, entries[i].exp_wb);
    endtask

    initial begin
        repeat (reset_cycles + num_entries * entry_cycles) @(posedge clk);
        $display("watchdog expired: the cache stopped answering and the run is hung");
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    initial begin
        cbus_req_t  idle_req;
        dbus_resp_t quiet_resp;
        dreq       = '0;
        idle_req   = '0;
        quiet_resp = '0;
        build_table();
        @(posedge clk);
        // first request already pending while reset is held
        dreq.valid    <= 1'b1;
        dreq.addr.raw <= entries[0].addr;
        dreq.strobe   <= entries[0].strobe;
        dreq.data     <= entries[0].data;
        // the last of these checks falls just after reset is released
        repeat (reset_cycles) begin
            @(negedge clk);
            compare_ctrl("memory request around reset", dcreq, idle_req);
            compare_handshake("core response around reset", dresp, quiet_resp);
        end
        for (int i = 0; i < num_entries; i++) begin
            run_request(i);
        end
        @(negedge clk);
        compare_ctrl("memory request after the last entry", dcreq, idle_req);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/dcache_pkg.sv
dcache/dcache_tag_array.sv
dcache/dcache_plru.sv
dcache/dcache_data_array.sv
dcache/dcache_miss_ctrl.sv
dcache/dcache_top.sv
verif/tb_clock_gen.sv
verif/mem_model.sv
verif/dcache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the dcache testbench with Verilator and runs it.
# The exit status is the simulator's: nonzero when the testbench fails.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing -j 0 \
    --top-module dcache_tb \
    -f filelist.f \
    --Mdir obj_dir \
    -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0
